// ==== morse_top.f ====
+incdir+design
design/morse_pkg.sv
design/morse_char_rom.sv
design/morse_keyer.sv
design/morse_decoder.sv
design/morse_top.sv
bench/morse_props.sv
bench/morse_tb.sv

// ==== Makefile ====
# Verilator build and run for the Morse keyer and decoder

VERILATOR ?= verilator
TOP       ?= morse_tb
FILELIST  ?= morse_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := design/morse_settings.svh
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit code
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/morse_tb.sv ====
`timescale 1ns/1ns
`include "morse_settings.svh"

module morse_tb;

        // well above the total length of all tests
        localparam int max_cycles = 6000;

        logic                     clk = 1'b0;
        logic                     rst;
        logic                     dot_in;
        logic                     dash_in;
        logic                     char_gap_in;
        logic                     word_gap_in;
        logic [`MORSE_CHAR_W-1:0] sout;

        int    cycle = 0;
        int    value_errors = 0;
        int    other_errors = 0;
        int    n_expected = 0;
        int    seed;
        string pending;

        logic [`MORSE_CHAR_W-1:0] exp_char [$];
        int                       exp_cycle [$];
        logic [`MORSE_CHAR_W-1:0] rx_char [$];

        // letter codes a to z
        string morse_table [0:25] = '{
                ".-", "-...", "-.-.", "-..", ".", "..-.", "--.", "....", "..",
                ".---", "-.-", ".-..", "--", "-.", "---", ".--.", "--.-", ".-.",
                "...", "-", "..-", "...-", ".--", "-..-", "-.--", "--.."
        };

        morse_top u_morse_top (
                .clk         (clk),
                .rst         (rst),
                .dot_in      (dot_in),
                .dash_in     (dash_in),
                .char_gap_in (char_gap_in),
                .word_gap_in (word_gap_in),
                .sout        (sout)
        );

        bind morse_top morse_props u_props (
                .clk  (clk),
                .rst  (rst),
                .sym  (sym),
                .sout (sout)
        );

        always #20 clk = ~clk;

        function automatic logic [7:0] ref_char(input string code);
                logic [7:0] res;
                res = `MORSE_NO_CHAR;
                for (int i = 0; i < 26; i++) begin
                        if (code == morse_table[i])
                                res = 8'h61 + 8'(i);
                end
                return res;
        endfunction

        // space only when nothing is pending
        function automatic logic [7:0] ref_word_gap(input string code);
                return (code.len() == 0) ? `MORSE_SPACE : `MORSE_NO_CHAR;
        endfunction

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        value_errors++;
                        $display("error at %0t ns: %s is %0h, expected %0h",
                                 $time, what, got, exp);
                end
        endtask

        task automatic expect_char(input logic [7:0] c, input int gap);
                if (c !== `MORSE_NO_CHAR) begin
                        exp_char.push_back(c);
                        exp_cycle.push_back(cycle + gap + 1);
                        n_expected++;
                end
        endtask

        // keys is {dot, dash, char gap, word gap}
        // noise holds dot and dash high while the keyer is busy
        task automatic key(input logic [3:0] keys, input bit noise);
                int wait_cycles;
                if (keys[3]) begin
                        pending = {pending, "."};
                        wait_cycles = 2;
                end else if (keys[2]) begin
                        pending = {pending, "-"};
                        wait_cycles = 2;
                end else if (keys[1]) begin
                        expect_char(ref_char(pending), `MORSE_CHAR_GAP);
                        pending = "";
                        wait_cycles = `MORSE_CHAR_GAP + 1;
                end else begin
                        expect_char(ref_word_gap(pending), `MORSE_WORD_GAP);
                        pending = "";
                        wait_cycles = `MORSE_WORD_GAP + 1;
                end
                {dot_in, dash_in, char_gap_in, word_gap_in} = keys;
                @(negedge clk);
                {dot_in, dash_in, char_gap_in, word_gap_in} = 4'b0000;
                if (noise)
                        {dot_in, dash_in} = 2'b11;
                repeat (wait_cycles - 1) @(negedge clk);
                {dot_in, dash_in} = 2'b00;
        endtask

        task automatic send_code(input string code);
                for (int i = 0; i < code.len(); i++) begin
                        if (code[i] == "-")
                                key(4'b0100, 1'b0);
                        else
                                key(4'b1000, 1'b0);
                end
        endtask

        task automatic send_letter(input string code);
                send_code(code);
                key(4'b0010, 1'b0);
        endtask

        task automatic apply_reset(input int n);
                rst = 1'b0;
                @(negedge clk);
                check_value("sout during reset", 32'(sout), 32'(`MORSE_NO_CHAR));
                repeat (n - 1) @(negedge clk);
                rst = 1'b1;
                pending = "";
        endtask

        // compare outputs against the expected queue
        always @(negedge clk) begin
                if (rst) begin
                        if (sout !== `MORSE_NO_CHAR)
                                rx_char.push_back(sout);
                        if (exp_cycle.size() > 0 && exp_cycle[0] == cycle) begin
                                check_value("sout", 32'(sout), 32'(exp_char[0]));
                                void'(exp_char.pop_front());
                                void'(exp_cycle.pop_front());
                        end else if (sout !== `MORSE_NO_CHAR) begin
                                other_errors++;
                                $display("unexpected character %h on sout at %0t ns",
                                         sout, $time);
                        end
                end
        end

        always @(posedge clk) begin
                cycle <= cycle + 1;
                if (cycle == max_cycles) begin
                        other_errors++;
                        $display("timeout, run did not finish within %0d cycles", max_cycles);
                        $display("errors: %0d value, %0d other", value_errors, other_errors);
                        $display("Testbench failed");
                        $finish;
                end
        end

        initial begin
                int r;
                rst = 1'b1;
                {dot_in, dash_in, char_gap_in, word_gap_in} = 4'b0000;
                seed = 32'h13dc_0095;
                pending = "";
                // reset falls ahead of the first rising edge
                #1;
                apply_reset(10);
                @(negedge clk);

                for (int i = 0; i < 26; i++)
                        send_letter(morse_table[i]);

                // empty word gap and word gap mid character
                key(4'b0001, 1'b0);
                send_code(".-");
                key(4'b0001, 1'b0);

                // invalid codes followed by a valid letter
                send_letter("..--");
                send_letter(".....");
                key(4'b0010, 1'b0);
                send_letter("-.-.");

                // priority and keys while busy
                key(4'b1100, 1'b0);
                key(4'b0110, 1'b0);
                key(4'b0011, 1'b0);
                send_code("-");
                key(4'b0010, 1'b1);
                key(4'b0001, 1'b1);

                // reset mid character
                send_code("-.");
                @(negedge clk);
                apply_reset(3);
                send_letter("-.-");

                for (int n = 0; n < 40; n++) begin
                        r = $random(seed);
                        if ($unsigned(r) % 5 == 0)
                                key(4'b0001, 1'b0);
                        else
                                send_letter(morse_table[$unsigned(r) % 26]);
                end

                repeat (4) @(negedge clk);
                check_value("received count", 32'(rx_char.size()), 32'(n_expected));
                if (exp_cycle.size() != 0) begin
                        other_errors++;
                        $display("%0d expected characters never arrived", exp_cycle.size());
                end
                $display("errors: %0d value, %0d other", value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

// ==== bench/morse_props.sv ====
`timescale 1ns/1ns
`include "morse_settings.svh"

module morse_props
        import morse_pkg::*;
(
        input logic                     clk,
        input logic                     rst,
        input morse_sym_t               sym,
        input logic [`MORSE_CHAR_W-1:0] sout
);

        // every symbol is a single cycle
        sym_one_cycle: assert property (@(posedge clk) disable iff (!rst)
                sym != sym_none |=> sym == sym_none)
                else $error("symbol held longer than one cycle");

        // output characters are single cycle pulses
        sout_one_cycle: assert property (@(posedge clk) disable iff (!rst)
                sout != `MORSE_NO_CHAR |=> sout == `MORSE_NO_CHAR)
                else $error("sout held a character longer than one cycle");

        // characters only come out right after a gap symbol
        sout_after_gap: assert property (@(posedge clk) disable iff (!rst)
                sout != `MORSE_NO_CHAR |->
                        ($past(sym) == sym_char_gap || $past(sym) == sym_word_gap))
                else $error("sout changed without a preceding gap symbol");

        reset_values: assert property (@(posedge clk)
                !rst |-> (sym == sym_none && sout == `MORSE_NO_CHAR))
                else $error("sym or sout not at reset value during reset");

endmodule

// ==== design/morse_top.sv ====
`timescale 1ns/1ns
`include "morse_settings.svh"

module morse_top
        import morse_pkg::*;
(
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     dot_in,
        input  logic                     dash_in,
        input  logic                     char_gap_in,
        input  logic                     word_gap_in,
        output logic [`MORSE_CHAR_W-1:0] sout
);

        // symbol stream, no back-pressure
        morse_sym_t sym;

        morse_keyer u_keyer (
                .clk         (clk),
                .rst         (rst),
                .dot_in      (dot_in),
                .dash_in     (dash_in),
                .char_gap_in (char_gap_in),
                .word_gap_in (word_gap_in),
                .sym         (sym)
        );

        morse_decoder u_decoder (
                .clk  (clk),
                .rst  (rst),
                .sym  (sym),
                .sout (sout)
        );

endmodule

// ==== design/morse_decoder.sv ====
`timescale 1ns/1ns
`include "morse_settings.svh"

module morse_decoder
        import morse_pkg::*;
(
        input  logic                     clk,
        input  logic                     rst,
        input  morse_sym_t               sym,
        output logic [`MORSE_CHAR_W-1:0] sout
);

        localparam int idx_w = `MORSE_MAX_DEPTH + 1;
        localparam logic [idx_w-1:0] root_idx = idx_w'(1);

        logic [idx_w-1:0]         index;
        logic                     invalid;
        logic                     full;
        logic [`MORSE_CHAR_W-1:0] rom_char;

        morse_char_rom u_rom (
                .index     (index),
                .char_code (rom_char)
        );

        // marker bit reached the top, no room for another symbol
        assign full = index[idx_w-1];

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        index   <= root_idx;
                        invalid <= 1'b0;
                        sout    <= `MORSE_NO_CHAR;
                end else begin
                        sout <= `MORSE_NO_CHAR;
                        case (sym)
                        sym_dot, sym_dash: begin
                                // dot appends 0, dash appends 1
                                if (full)
                                        invalid <= 1'b1;
                                else
                                        index <= {index[idx_w-2:0], sym == sym_dash};
                        end
                        sym_char_gap: begin
                                sout    <= invalid ? `MORSE_NO_CHAR : rom_char;
                                index   <= root_idx;
                                invalid <= 1'b0;
                        end
                        sym_word_gap: begin
                                // pending character is dropped silently
                                if (index == root_idx)
                                        sout <= `MORSE_SPACE;
                                index   <= root_idx;
                                invalid <= 1'b0;
                        end
                        default: ;
                        endcase
                end
        end

endmodule

// ==== design/morse_keyer.sv ====
`timescale 1ns/1ns
`include "morse_settings.svh"

module morse_keyer
        import morse_pkg::*;
(
        input  logic       clk,
        input  logic       rst,
        input  logic       dot_in,
        input  logic       dash_in,
        input  logic       char_gap_in,
        input  logic       word_gap_in,
        output morse_sym_t sym
);

        localparam int cnt_w = $clog2(`MORSE_WORD_GAP);

        localparam logic [1:0] st_idle = 2'd0;
        localparam logic [1:0] st_mark = 2'd1;
        localparam logic [1:0] st_gap  = 2'd2;

        logic [1:0]       state;
        logic [cnt_w-1:0] cnt;
        morse_sym_t       pick;
        morse_sym_t       held;

        // dot over dash over char gap over word gap
        always_comb begin
                if (dot_in)
                        pick = sym_dot;
                else if (dash_in)
                        pick = sym_dash;
                else if (char_gap_in)
                        pick = sym_char_gap;
                else if (word_gap_in)
                        pick = sym_word_gap;
                else
                        pick = sym_none;
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        state <= st_idle;
                        cnt   <= '0;
                end else begin
                        case (state)
                        st_idle: begin
                                case (pick)
                                sym_dot, sym_dash: state <= st_mark;
                                sym_char_gap: begin
                                        state <= st_gap;
                                        cnt   <= cnt_w'(`MORSE_CHAR_GAP - 1);
                                end
                                sym_word_gap: begin
                                        state <= st_gap;
                                        cnt   <= cnt_w'(`MORSE_WORD_GAP - 1);
                                end
                                default: state <= st_idle;
                                endcase
                        end
                        st_mark: state <= st_idle;
                        st_gap: begin
                                // gap symbol goes out in the cycle where cnt is zero
                                if (cnt == '0)
                                        state <= st_idle;
                                else
                                        cnt <= cnt - 1'b1;
                        end
                        default: state <= st_idle;
                        endcase
                end
        end

        // symbol latched on the sampling edge, inputs ignored while busy
        always_ff @(posedge clk) begin
                if (state == st_idle)
                        held <= pick;
        end

        assign sym = (state == st_mark || (state == st_gap && cnt == '0)) ? held : sym_none;

endmodule

// ==== design/morse_char_rom.sv ====
`timescale 1ns/1ns
`include "morse_settings.svh"

// index is a leading 1 followed by the keyed symbols, dot 0 and dash 1
module morse_char_rom (
        input  logic [`MORSE_MAX_DEPTH:0]  index,
        output logic [`MORSE_CHAR_W-1:0]   char_code
);

        always_comb begin
                case (index)
                // one symbol
                2:  char_code = "e";
                3:  char_code = "t";
                // two symbols
                4:  char_code = "i";
                5:  char_code = "a";
                6:  char_code = "n";
                7:  char_code = "m";
                // three symbols
                8:  char_code = "s";
                9:  char_code = "u";
                10: char_code = "r";
                11: char_code = "w";
                12: char_code = "d";
                13: char_code = "k";
                14: char_code = "g";
                15: char_code = "o";
                // four symbols, gaps in the table have no letter
                16: char_code = "h";
                17: char_code = "v";
                18: char_code = "f";
                20: char_code = "l";
                22: char_code = "p";
                23: char_code = "j";
                24: char_code = "b";
                25: char_code = "x";
                26: char_code = "c";
                27: char_code = "y";
                28: char_code = "z";
                29: char_code = "q";
                default: char_code = `MORSE_NO_CHAR;
                endcase
        end

endmodule

// ==== design/morse_pkg.sv ====
package morse_pkg;

        // symbol stream between keyer and decoder
        typedef enum logic [2:0] {
                sym_none     = 3'd0,
                sym_dot      = 3'd1,
                sym_dash     = 3'd2,
                sym_char_gap = 3'd3,
                sym_word_gap = 3'd4
        } morse_sym_t;

endpackage

// ==== design/morse_settings.svh ====
`ifndef MORSE_SETTINGS_SVH
`define MORSE_SETTINGS_SVH

// gap lengths in clock cycles
`define MORSE_CHAR_GAP 3
`define MORSE_WORD_GAP 7

// deepest tree level that still holds a letter
`define MORSE_MAX_DEPTH 4

// output character width
`define MORSE_CHAR_W 8

// special output codes
`define MORSE_NO_CHAR 8'hff
`define MORSE_SPACE 8'h20

`endif
